// File: Bender.yml
package:
  name: collision_force

sources:
  - include_dirs:
      - design
    files:
      - design/collision_pkg.sv
      - design/heading_decoder.sv
      - design/pair_select.sv
      - design/impact_response.sv
      - design/collision_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - tests/collision_tb.sv

// File: design/collision_cfg.svh
/*
 * Width and size macros for the collision force unit
 */

`ifndef COLLISION_CFG_SVH
`define COLLISION_CFG_SVH

// Signed velocity and force component width
`define COLL_VEL_W 17

// Pig plus three birds
`define COLL_NUM_BODIES 4

// Raw heading code width
`define COLL_HEAD_W 4

// Decoded compass octant width
`define COLL_OCT_W 3

`endif

// File: design/collision_pkg.sv
/*
 * Shared packed types for the collision force unit:
 * velocities, bodies, collide mask, octants, striker/target pair, forces
 */

`include "collision_cfg.svh"

package collision_pkg;

    typedef logic signed [`COLL_VEL_W-1:0] vel_t;

    typedef struct packed {
        vel_t x;
        vel_t y;
    } vec_t;

    typedef struct packed {
        vec_t                    vel;
        logic [`COLL_HEAD_W-1:0] head;
    } body_t;

    // Body 0 is the pig, 1 to 3 are birds
    typedef body_t [`COLL_NUM_BODIES-1:0] bodies_t;

    typedef logic [`COLL_NUM_BODIES-1:0] mask_t;

    typedef logic [$clog2(`COLL_NUM_BODIES)-1:0] body_idx_t;

    // 0 is up, clockwise to 7 at upper left
    typedef logic [`COLL_OCT_W-1:0] octant_t;

    typedef octant_t [`COLL_NUM_BODIES-1:0] octants_t;

    typedef struct packed {
        logic      valid;
        body_idx_t striker;
        body_idx_t target;
        vec_t      v_s;
        vec_t      v_t;
    } pair_t;

    typedef vec_t [`COLL_NUM_BODIES-1:0] forces_t;

endpackage

// File: design/collision_top.sv
/*
 * Collision force unit top: heading decoder and pair selector
 * side by side, feeding the impact response register stage
 */

`timescale 1ns/100ps

module collision_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    vsync,
    input  collision_pkg::mask_t    collide,
    input  collision_pkg::bodies_t  bodies,
    output collision_pkg::forces_t  forces
);

    collision_pkg::octants_t octs;
    collision_pkg::pair_t    pair;

    heading_decoder heading_decoder_i (
        .bodies (bodies),
        .octs   (octs)
    );

    pair_select pair_select_i (
        .collide (collide),
        .bodies  (bodies),
        .pair    (pair)
    );

    // One cycle from a vsync edge to the forces output
    impact_response impact_response_i (
        .clk    (clk),
        .rst    (rst),
        .vsync  (vsync),
        .pair   (pair),
        .octs   (octs),
        .forces (forces)
    );

endmodule

// File: design/heading_decoder.sv
/*
 * Heading decoder: raw heading code of every body to a compass octant
 */

`timescale 1ns/100ps

`include "collision_cfg.svh"

module heading_decoder (
    input  collision_pkg::bodies_t  bodies,
    output collision_pkg::octants_t octs
);

    /*
     * 7 0 1
     * 6   2
     * 5 4 3
     */
    function automatic collision_pkg::octant_t decode(
        input logic [`COLL_HEAD_W-1:0] code
    );
        collision_pkg::octant_t oct;
        casez (code)
            4'b11??:          oct = 3'd0;
            4'b1000, 4'b1010: oct = 3'd0;
            4'b1001, 4'b1011: oct = 3'd4;
            4'b0110, 4'b0111: oct = 3'd2;
            4'b0100, 4'b0101: oct = 3'd6;
            4'b0010:          oct = 3'd1;
            4'b0011:          oct = 3'd3;
            4'b0001:          oct = 3'd5;
            4'b0000:          oct = 3'd7;
            default:          oct = 3'd0;
        endcase
        return oct;
    endfunction

    // All bodies in parallel, the striker is picked later
    always_comb begin
        for (int i = 0; i < `COLL_NUM_BODIES; i++) begin
            octs[i] = decode(bodies[i].head);
        end
    end

endmodule

// File: design/impact_response.sv
/*
 * Impact response: octant force rule for a striker/target pair,
 * per-body force register loaded on vsync
 */

`timescale 1ns/100ps

module impact_response (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     vsync,
    input  collision_pkg::pair_t     pair,
    input  collision_pkg::octants_t  octs,
    output collision_pkg::forces_t   forces
);

    collision_pkg::octant_t oct;
    collision_pkg::vec_t    s;
    collision_pkg::vec_t    t;
    collision_pkg::vel_t    sx_half;
    collision_pkg::vel_t    sx_quarter;
    collision_pkg::vel_t    sy_half;
    collision_pkg::vec_t    f_s;
    collision_pkg::vec_t    f_t;
    collision_pkg::forces_t forces_next;

    // Heading of the striker decides the rule
    assign oct = octs[pair.striker];

    assign s = pair.v_s;
    assign t = pair.v_t;

    // Arithmetic shifts keep the sign
    assign sx_half    = s.x >>> 1;
    assign sx_quarter = s.x >>> 2;
    assign sy_half    = s.y >>> 1;

    always_comb begin
        // Striker recoils against the target's velocity
        if (oct == 3'd0) begin
            f_s.x = t.x - sx_quarter;
        end else begin
            f_s.x = t.x - sx_half;
        end

        if (oct == 3'd2) begin
            f_s.y = t.y;
        end else begin
            f_s.y = t.y - sy_half;
        end

        // Target takes the striker's momentum, full or halved
        case (oct)
            3'd1, 3'd2, 3'd7: f_t.x = s.x;
            3'd5:             f_t.x = -sx_half;
            default:          f_t.x = sx_half;
        endcase

        case (oct)
            3'd0, 3'd1, 3'd6, 3'd7: f_t.y = s.y;
            default:                f_t.y = sy_half;
        endcase
    end

    // Uninvolved bodies get zero
    always_comb begin
        forces_next = '0;
        if (pair.valid) begin
            forces_next[pair.striker] = f_s;
            forces_next[pair.target]  = f_t;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            forces <= '0;
        end else if (vsync) begin
            forces <= forces_next;
        end
    end

    a_reset_zero: assert property (
        @(posedge clk) rst |=> (forces == '0)
    ) else $error("impact_response: forces not zero after reset");

    // Between frame strobes the output must not move
    a_hold: assert property (
        @(posedge clk) disable iff (rst) !vsync |=> $stable(forces)
    ) else $error("impact_response: forces changed without vsync");

endmodule

// File: design/pair_select.sv
/*
 * Pair selector: recognises a two-body collide mask and routes
 * the striker and target velocities
 */

`timescale 1ns/100ps

`include "collision_cfg.svh"

module pair_select (
    input  collision_pkg::mask_t   collide,
    input  collision_pkg::bodies_t bodies,
    output collision_pkg::pair_t   pair
);

    logic [$clog2(`COLL_NUM_BODIES+1)-1:0] count;
    collision_pkg::body_idx_t              lo;
    collision_pkg::body_idx_t              hi;
    logic                                  found;

    // Lowest set bit is the target, highest is the striker
    always_comb begin
        count = '0;
        lo    = '0;
        hi    = '0;
        found = 1'b0;
        for (int i = 0; i < `COLL_NUM_BODIES; i++) begin
            if (collide[i]) begin
                count = count + 1'b1;
                hi    = collision_pkg::body_idx_t'(i);
                if (!found) begin
                    lo    = collision_pkg::body_idx_t'(i);
                    found = 1'b1;
                end
            end
        end
    end

    always_comb begin
        pair.valid   = (count == 2);
        pair.striker = hi;
        pair.target  = lo;
        if (pair.valid) begin
            pair.v_s = bodies[hi].vel;
            pair.v_t = bodies[lo].vel;
        end else begin
            pair.v_s = '0;
            pair.v_t = '0;
        end
    end

    // Striker must always sit above target in body order
    a_pair_order: assert final (
        $isunknown(pair) || !pair.valid || (pair.striker > pair.target)
    ) else $error("pair_select: striker %0d not above target %0d",
                  pair.striker, pair.target);

endmodule

// File: sources.f
+incdir+design
design/collision_pkg.sv
design/heading_decoder.sv
design/pair_select.sv
design/impact_response.sv
design/collision_top.sv
tests/collision_tb.sv

// File: tests/collision_tb.sv
/*
 * Collision force unit testbench: stimulus table, reference force model,
 * per-body checks and watchdog
 */

`timescale 1ns/100ps

`include "collision_cfg.svh"

module collision_tb;

    localparam realtime clk_period = 8.0;

    typedef struct packed {
        collision_pkg::mask_t                            mask;
        logic [`COLL_NUM_BODIES-1:0][`COLL_HEAD_W-1:0]  heads;
        logic                                            vsync;
        logic                                            rand_vel;
    } stim_t;

    // Raw heading code that lands in each octant
    localparam logic [3:0] oct_code [8] = '{
        4'b1000, 4'b0010, 4'b0110, 4'b0011, 4'b1001, 4'b0001, 4'b0100, 4'b0000
    };
    localparam collision_pkg::mask_t pair_masks [6] = '{
        4'b0011, 4'b0101, 4'b1001, 4'b0110, 4'b1010, 4'b1100
    };
    localparam collision_pkg::mask_t bad_masks [10] = '{
        4'b0000, 4'b0001, 4'b0010, 4'b0100, 4'b1000,
        4'b0111, 4'b1011, 4'b1101, 4'b1110, 4'b1111
    };

    logic                   clk = 1'b0;
    logic                   rst;
    logic                   vsync;
    collision_pkg::mask_t   collide;
    collision_pkg::bodies_t bodies;
    collision_pkg::forces_t forces;

    stim_t                  stim_table [$];
    logic                   table_ready = 1'b0;
    collision_pkg::vec_t    fixed_vel [`COLL_NUM_BODIES];
    collision_pkg::forces_t exp_forces;
    logic [31:0]            rng_state;
    int                     errors;
    int                     checks;

    collision_top collision_top_i (
        .clk     (clk),
        .rst     (rst),
        .vsync   (vsync),
        .collide (collide),
        .bodies  (bodies),
        .forces  (forces)
    );

    always #(clk_period / 2) clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] v;
        v = x;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    function automatic int top_bit(input collision_pkg::mask_t m);
        int idx;
        idx = -1;
        for (int i = 0; i < `COLL_NUM_BODIES; i++) begin
            if (m[i]) begin
                idx = i;
            end
        end
        return idx;
    endfunction

    // Compass octant straight from the heading table
    function automatic int octant_of(input logic [3:0] code);
        int oct;
        if (code[3:2] == 2'b11) begin
            oct = 0;
        end else if (code[3]) begin
            oct = code[0] ? 4 : 0;
        end else if (code[2]) begin
            oct = code[1] ? 2 : 6;
        end else begin
            case (code[1:0])
                2'b10:   oct = 1;
                2'b11:   oct = 3;
                2'b01:   oct = 5;
                default: oct = 7;
            endcase
        end
        return oct;
    endfunction

    function automatic collision_pkg::forces_t expected_forces(
        input collision_pkg::mask_t   m,
        input collision_pkg::bodies_t b
    );
        collision_pkg::forces_t f;
        int tgt;
        int str;
        int oct;
        int sx;
        int sy;
        int tx;
        int ty;
        f = '0;
        if ($countones(m) != 2) begin
            return f;
        end
        tgt = -1;
        str = -1;
        for (int i = 0; i < `COLL_NUM_BODIES; i++) begin
            if (m[i] && tgt < 0) begin
                tgt = i;
            end else if (m[i]) begin
                str = i;
            end
        end
        oct = octant_of(b[str].head);
        sx = b[str].vel.x;
        sy = b[str].vel.y;
        tx = b[tgt].vel.x;
        ty = b[tgt].vel.y;
        f[str].x = collision_pkg::vel_t'((oct == 0) ? tx - (sx >>> 2) : tx - (sx >>> 1));
        f[str].y = collision_pkg::vel_t'((oct == 2) ? ty : ty - (sy >>> 1));
        if (oct inside {1, 2, 7}) begin
            f[tgt].x = collision_pkg::vel_t'(sx);
        end else if (oct == 5) begin
            f[tgt].x = collision_pkg::vel_t'(-(sx >>> 1));
        end else begin
            f[tgt].x = collision_pkg::vel_t'(sx >>> 1);
        end
        f[tgt].y = collision_pkg::vel_t'((oct inside {0, 1, 6, 7}) ? sy : sy >>> 1);
        return f;
    endfunction

    task automatic add_entry(
        input collision_pkg::mask_t                           m,
        input logic [`COLL_NUM_BODIES-1:0][`COLL_HEAD_W-1:0] h,
        input logic                                           vs,
        input logic                                           rnd
    );
        stim_t e;
        e.mask     = m;
        e.heads    = h;
        e.vsync    = vs;
        e.rand_vel = rnd;
        stim_table.push_back(e);
    endtask

    task automatic build_table();
        logic [`COLL_NUM_BODIES-1:0][`COLL_HEAD_W-1:0] h;
        int str;
        // Extremes so that shifts and negation wrap
        fixed_vel[0] = '{x: 17'h0ffff, y: -17'sd3};
        fixed_vel[1] = '{x: 17'h10000, y: 17'sd7};
        fixed_vel[2] = '{x: -17'sd5, y: 17'h10000};
        fixed_vel[3] = '{x: 17'sd40000, y: -17'sd40001};
        // Valid pair without vsync straight out of reset
        add_entry(4'b0011, '0, 1'b0, 1'b0);
        foreach (pair_masks[m]) begin
            str = top_bit(pair_masks[m]);
            for (int o = 0; o < 8; o++) begin
                for (int b = 0; b < `COLL_NUM_BODIES; b++) begin
                    h[b] = 4'((m * 3 + o + b * 5) % 16);
                end
                h[str] = oct_code[o];
                add_entry(pair_masks[m], h, 1'b1, 1'((o + m) % 2));
            end
        end
        foreach (bad_masks[k]) begin
            add_entry(4'b1001, 16'h2222, 1'b1, 1'b1);
            add_entry(bad_masks[k], 16'h7a5c, 1'b1, 1'b1);
        end
        add_entry(4'b0110, 16'h6666, 1'b1, 1'b0);
        add_entry(4'b1100, 16'h0000, 1'b0, 1'b1);
        add_entry(4'b0000, 16'h1111, 1'b0, 1'b1);
        add_entry(4'b1010, 16'h3333, 1'b1, 1'b1);
        add_entry(4'b0101, 16'h5555, 1'b0, 1'b0);
        // Every raw heading code on the striker
        for (int c = 0; c < 16; c++) begin
            foreach (pair_masks[m]) begin
                h = 16'h9999;
                h[top_bit(pair_masks[m])] = 4'(c);
                add_entry(pair_masks[m], h, 1'b1, 1'b1);
            end
        end
    endtask

    task automatic apply_entry(input stim_t e);
        collision_pkg::bodies_t b;
        for (int i = 0; i < `COLL_NUM_BODIES; i++) begin
            if (e.rand_vel) begin
                rng_state = xorshift(rng_state);
                b[i].vel.x = collision_pkg::vel_t'(rng_state[16:0]);
                rng_state = xorshift(rng_state);
                b[i].vel.y = collision_pkg::vel_t'(rng_state[16:0]);
            end else begin
                b[i].vel = fixed_vel[i];
            end
            b[i].head = e.heads[i];
        end
        collide = e.mask;
        bodies  = b;
        vsync   = e.vsync;
        if (e.vsync) begin
            exp_forces = expected_forces(e.mask, b);
        end
    endtask

    task automatic check_forces(input int idx);
        for (int i = 0; i < `COLL_NUM_BODIES; i++) begin
            checks = checks + 2;
            if (forces[i].x !== exp_forces[i].x) begin
                errors++;
                $display("mismatch at %0t: entry %0d body %0d x expected %0d got %0d",
                         $time, idx, i, exp_forces[i].x, forces[i].x);
            end
            if (forces[i].y !== exp_forces[i].y) begin
                errors++;
                $display("mismatch at %0t: entry %0d body %0d y expected %0d got %0d",
                         $time, idx, i, exp_forces[i].y, forces[i].y);
            end
        end
    endtask

    initial begin
        rst        = 1'b1;
        vsync      = 1'b0;
        collide    = '0;
        bodies     = '0;
        errors     = 0;
        checks     = 0;
        rng_state  = 32'd25;
        exp_forces = '0;
        build_table();
        table_ready = 1'b1;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        check_forces(-1);
        for (int i = 0; i < stim_table.size(); i++) begin
            apply_entry(stim_table[i]);
            @(posedge clk);
            #1;
            check_forces(i);
        end
        $display("%0d entries, %0d checks, %0d errors", stim_table.size(), checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // Watchdog scaled to the table length
    initial begin
        wait (table_ready);
        #(2 * stim_table.size() * 4 * clk_period);
        $display("timeout: the stimulus table did not complete in time");
        $display("Finished with errors");
        $finish;
    end

endmodule
